// File: verilog/noc_pkg.sv
`default_nettype none

package noc_pkg;

    // Flit layout is {vc, dest[3:0], payload[26:0]}
    typedef logic [31:0] flit_t;

    // Destination node number, also the route table index
    typedef logic [3:0] node_id_t;

    typedef logic [1:0] port_sel_t;  // Output or input port index

    localparam int NUM_PORTS = 3;    // Inputs and outputs alike
    localparam int NUM_VCS = 2;      // Per input port

    localparam int FIFO_DEPTH = 4;   // Flits per VC, power of two
    localparam int TABLE_SIZE = 16;  // One entry per node

    // Field positions inside flit_t
    localparam int FLIT_VC_BIT = 31;
    localparam int DEST_MSB = 30;
    localparam int DEST_LSB = 27;

endpackage

`default_nettype wire

// File: verilog/flit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module flit_fifo (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           wr_en,
    input  noc_pkg::flit_t wr_flit,
    input  logic           rd_en,
    output noc_pkg::flit_t rd_flit,
    output logic           full,
    output logic           empty
);
    import noc_pkg::*;

    flit_t mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr_flit;
    end

    assign rd_flit = mem[rd_ptr];  // Head visible without latency
    assign full = (int'(count) == FIFO_DEPTH);
    assign empty = (count == '0);

    // Callers must respect full and empty
    assert property (@(posedge clk) disable iff (!n_rst)
        !(wr_en && full) && !(rd_en && empty))
        else $error("flit_fifo overflow or underflow");

endmodule

`default_nettype wire

// File: verilog/route_table.sv
`timescale 1ns/100ps
`default_nettype none

module route_table (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [7:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  noc_pkg::flit_t      head_flit [noc_pkg::NUM_PORTS],
    output noc_pkg::port_sel_t  head_port [noc_pkg::NUM_PORTS]
);
    import noc_pkg::*;

    port_sel_t table_q [TABLE_SIZE];

    logic     access;
    logic     addr_bad;
    logic     data_bad;
    node_id_t apb_idx;
    node_id_t head_dest [NUM_PORTS];

    assign access = psel && penable;
    assign apb_idx = paddr[5:2];
    assign addr_bad = (paddr > 8'(4 * (TABLE_SIZE - 1)));
    assign data_bad = pwrite && (pwdata[1:0] == 2'b11);  // Port 3 does not exist

    assign pready = 1'b1;
    assign pslverr = access && (addr_bad || data_bad);
    assign prdata = addr_bad ? '0 : 32'(table_q[apb_idx]);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int n = 0; n < TABLE_SIZE; n++)
                table_q[n] <= port_sel_t'(n % NUM_PORTS);  // Default spread
        end else if (access && pwrite && !addr_bad && !data_bad) begin
            table_q[apb_idx] <= pwdata[1:0];
        end
    end

    // Lookup per input head
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            head_dest[p] = head_flit[p][DEST_MSB:DEST_LSB];
            head_port[p] = table_q[head_dest[p]];
        end
    end

    for (genvar n = 0; n < TABLE_SIZE; n++) begin : g_chk
        assert property (@(posedge clk) disable iff (!n_rst)
            table_q[n] != 2'd3)
            else $error("route_table entry %0d holds invalid port", n);
    end

endmodule

`default_nettype wire

// File: verilog/switch_allocator.sv
`timescale 1ns/100ps
`default_nettype none

module switch_allocator (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic [noc_pkg::NUM_PORTS-1:0] head_valid,
    input  noc_pkg::port_sel_t            head_port [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::NUM_PORTS-1:0] out_free,
    output logic [noc_pkg::NUM_PORTS-1:0] grant_in,
    output noc_pkg::port_sel_t            grant_sel [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::NUM_PORTS-1:0] grant_valid
);
    import noc_pkg::*;

    port_sel_t rr_ptr [NUM_PORTS];              // Last winner per output
    logic [NUM_PORTS-1:0] grant_hits [NUM_PORTS];  // [input][output]

    always_comb begin
        int cand;
        grant_valid = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            grant_sel[o] = '0;
            // Walk backwards so the nearest requester after the pointer wins
            for (int k = NUM_PORTS; k >= 1; k--) begin
                cand = (int'(rr_ptr[o]) + k) % NUM_PORTS;
                if (out_free[o] && head_valid[cand] && (int'(head_port[cand]) == o)) begin
                    grant_valid[o] = 1'b1;
                    grant_sel[o] = port_sel_t'(cand);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int o = 0; o < NUM_PORTS; o++)
                grant_hits[i][o] = grant_valid[o] && (int'(grant_sel[o]) == i);
            grant_in[i] = |grant_hits[i];
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int o = 0; o < NUM_PORTS; o++)
                rr_ptr[o] <= port_sel_t'(NUM_PORTS - 1);  // Input 0 first
        end else begin
            for (int o = 0; o < NUM_PORTS; o++)
                if (grant_valid[o])
                    rr_ptr[o] <= grant_sel[o];
        end
    end

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_chk
        assert property (@(posedge clk) disable iff (!n_rst)
            $onehot0(grant_hits[g]) &&
            (!grant_valid[g] || (head_valid[grant_sel[g]] && head_port[grant_sel[g]] == g)))
            else $error("switch_allocator bad grant at port %0d", g);
    end

endmodule

`default_nettype wire

// File: verilog/crossbar.sv
`timescale 1ns/100ps
`default_nettype none

module crossbar (
    input  logic                          clk,
    input  logic                          n_rst,
    input  noc_pkg::flit_t                head_flit [noc_pkg::NUM_PORTS],
    input  noc_pkg::port_sel_t            grant_sel [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::NUM_PORTS-1:0] grant_valid,
    input  logic [noc_pkg::NUM_PORTS-1:0] out_ready,
    output logic [noc_pkg::NUM_PORTS-1:0] out_free,
    output noc_pkg::flit_t                out_flit [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::NUM_PORTS-1:0] out_valid
);
    import noc_pkg::*;

    assign out_free = ~out_valid | out_ready;  // Empty or draining now

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            out_valid <= '0;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (grant_valid[o])
                    out_valid[o] <= 1'b1;
                else if (out_ready[o])
                    out_valid[o] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++)
            if (grant_valid[o])
                out_flit[o] <= head_flit[grant_sel[o]];
    end

    // Stalled output must hold
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_chk
        assert property (@(posedge clk) disable iff (!n_rst)
            out_valid[g] && !out_ready[g] |=> out_valid[g] && $stable(out_flit[g]))
            else $error("crossbar output %0d changed while stalled", g);
    end

endmodule

`default_nettype wire

// File: verilog/noc_switch.sv
`timescale 1ns/100ps
`default_nettype none

module noc_switch (
    input  logic                          clk,
    input  logic                          n_rst,
    input  noc_pkg::flit_t                in_flit [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::NUM_PORTS-1:0] in_valid,
    output logic [noc_pkg::NUM_PORTS-1:0] in_ready_vc0,
    output logic [noc_pkg::NUM_PORTS-1:0] in_ready_vc1,
    output noc_pkg::flit_t                out_flit [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::NUM_PORTS-1:0] out_valid,
    input  logic [noc_pkg::NUM_PORTS-1:0] out_ready,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr
);
    import noc_pkg::*;

    // Per input, indexed by VC
    flit_t              fifo_head [NUM_PORTS][NUM_VCS];
    logic [NUM_VCS-1:0] fifo_wr [NUM_PORTS];
    logic [NUM_VCS-1:0] fifo_rd [NUM_PORTS];
    logic [NUM_VCS-1:0] fifo_full [NUM_PORTS];
    logic [NUM_VCS-1:0] fifo_empty [NUM_PORTS];

    logic [NUM_PORTS-1:0] vc_sel;   // Preferred VC when both have data
    logic [NUM_PORTS-1:0] cur_vc;   // VC offered this cycle

    flit_t                head_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] head_valid;
    port_sel_t            head_port [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_free;
    logic [NUM_PORTS-1:0] grant_in;
    port_sel_t            grant_sel [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant_valid;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            flit_fifo fifo_i (
                .clk     (clk),
                .n_rst   (n_rst),
                .wr_en   (fifo_wr[p][v]),
                .wr_flit (in_flit[p]),
                .rd_en   (fifo_rd[p][v]),
                .rd_flit (fifo_head[p][v]),
                .full    (fifo_full[p][v]),
                .empty   (fifo_empty[p][v])
            );
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_ready_vc0[p] = !fifo_full[p][0];
            in_ready_vc1[p] = !fifo_full[p][1];

            fifo_wr[p] = '0;  // Steer by VC bit
            fifo_wr[p][in_flit[p][FLIT_VC_BIT]] =
                in_valid[p] && !fifo_full[p][in_flit[p][FLIT_VC_BIT]];

            case (~fifo_empty[p])
                2'b01: cur_vc[p] = 1'b0;
                2'b10: cur_vc[p] = 1'b1;
                default: cur_vc[p] = vc_sel[p];
            endcase

            head_flit[p] = fifo_head[p][cur_vc[p]];
            head_valid[p] = !fifo_empty[p][cur_vc[p]];

            fifo_rd[p] = '0;
            fifo_rd[p][cur_vc[p]] = grant_in[p];  // Pop what was offered
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            vc_sel <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++)
                if (grant_in[p])
                    vc_sel[p] <= !cur_vc[p];  // Alternate after each pop
        end
    end

    route_table route_table_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .head_flit (head_flit),
        .head_port (head_port)
    );

    switch_allocator switch_allocator_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .head_valid  (head_valid),
        .head_port   (head_port),
        .out_free    (out_free),
        .grant_in    (grant_in),
        .grant_sel   (grant_sel),
        .grant_valid (grant_valid)
    );

    crossbar crossbar_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .head_flit   (head_flit),
        .grant_sel   (grant_sel),
        .grant_valid (grant_valid),
        .out_ready   (out_ready),
        .out_free    (out_free),
        .out_flit    (out_flit),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

// File: tb/noc_switch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module noc_switch_tb;
    import noc_pkg::*;

    localparam int MAX_CYCLES = 20000;  // About 3000 needed
    localparam int DRAIN_LIMIT = 2000;
    localparam int NUM_Q = NUM_PORTS * NUM_PORTS * NUM_VCS;

    logic                 clk;
    logic                 n_rst;
    flit_t                in_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid, in_ready_vc0, in_ready_vc1;
    flit_t                out_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid, out_ready;
    logic                 psel, penable, pwrite, pready, pslverr;
    logic [7:0]           paddr;
    logic [31:0]          pwdata, prdata;

    port_sel_t   shadow [TABLE_SIZE];  // Expected table contents
    flit_t       exp_q [NUM_Q][$];      // Per output, input and VC
    logic [15:0] seq_cnt [NUM_PORTS][NUM_VCS];
    flit_t       held_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] was_stalled;
    int          wait_cnt [NUM_PORTS];
    int          pending, errors, tests_run, tests_failed, cycles;
    logic [31:0] lfsr;
    logic        hot_mode, saw_full;

    noc_switch noc_switch_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic port_sel_t expected_port(input node_id_t dest);
        return shadow[dest];
    endfunction

    function automatic int q_index(input int o, input int i, input int v);
        return (o * NUM_PORTS + i) * NUM_VCS + v;
    endfunction

    // Payload {src, vc, 8'h00, seq}
    function automatic flit_t make_flit(input int p, input logic vc, input node_id_t dest,
                                        input logic [15:0] seq);
        return {vc, dest, 2'(p), vc, 8'h00, seq};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-18s ok", name);
        end else begin
            tests_failed++;
            $display("test %-18s %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        if (pready !== 1'b1)
            report_mismatch("pready", 32'd1, 32'(pready));
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic check_table();
        logic [31:0] rdata;
        logic err;
        for (int n = 0; n < TABLE_SIZE; n++) begin
            apb_access(1'b0, 8'(4 * n), '0, rdata, err);
            if (rdata !== 32'(shadow[n]))
                report_mismatch($sformatf("prdata[%0d]", n), 32'(shadow[n]), rdata);
            if (err)
                report_problem($sformatf("pslverr on valid read of entry %0d", n));
        end
    endtask

    // One flit in flight per input, held until its VC is ready
    task automatic run_traffic(input int count, input logic stall, input int dest,
                               input int only_in);
        int sent [NUM_PORTS];
        logic [NUM_PORTS-1:0] acc;
        logic [NUM_PORTS-1:0] offering;
        logic [31:0] r;
        logic vc;
        node_id_t d;
        int waited;
        offering = '0;
        waited = 0;
        for (int p = 0; p < NUM_PORTS; p++)
            sent[p] = (only_in < 0 || only_in == p) ? 0 : count;
        forever begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++)
                acc[p] = offering[p] &&
                    (in_flit[p][FLIT_VC_BIT] ? in_ready_vc1[p] : in_ready_vc0[p]);
            @(posedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (acc[p]) begin
                    vc = in_flit[p][FLIT_VC_BIT];
                    d = in_flit[p][DEST_MSB:DEST_LSB];
                    exp_q[q_index(int'(expected_port(d)), p, int'(vc))].push_back(in_flit[p]);
                    pending++;
                    sent[p]++;
                    offering[p] = 1'b0;
                end
                if (!offering[p] && sent[p] < count && rand_bits(2) != 0) begin
                    vc = 1'(rand_bits(1));
                    d = (dest < 0) ? node_id_t'(rand_bits(4)) : node_id_t'(dest);
                    in_flit[p] <= make_flit(p, vc, d, seq_cnt[p][vc]);
                    seq_cnt[p][vc]++;
                    offering[p] = 1'b1;
                end
                in_valid[p] <= offering[p];
            end
            r = rand_bits(NUM_PORTS) & rand_bits(NUM_PORTS);  // Ready one cycle in four
            out_ready <= stall ? r[NUM_PORTS-1:0] : '1;
            waited++;
            if (offering == '0 && pending == 0 && sent.sum() == count * NUM_PORTS)
                break;
            if (waited > DRAIN_LIMIT) begin
                report_problem($sformatf("traffic did not drain, %0d flits missing", pending));
                break;
            end
        end
        in_valid <= '0;
        out_ready <= '1;
    endtask

    // Scoreboard
    always @(negedge clk) begin
        int src;
        int vc;
        int qi;
        int backlog;
        flit_t exp;
        if (n_rst) begin
            for (int p = 0; p < NUM_PORTS; p++)
                for (int v = 0; v < NUM_VCS; v++)
                    if (!(v == 1 ? in_ready_vc1[p] : in_ready_vc0[p])) begin
                        saw_full = 1'b1;
                        backlog = 0;
                        for (int o = 0; o < NUM_PORTS; o++)
                            backlog += exp_q[q_index(o, p, v)].size();
                        if (backlog < FIFO_DEPTH)
                            report_problem($sformatf("input %0d VC %0d not ready with %0d flits",
                                                     p, v, backlog));
                    end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (was_stalled[o] && !out_valid[o])
                    report_problem($sformatf("output %0d dropped a stalled flit", o));
                else if (was_stalled[o] && out_flit[o] !== held_flit[o])
                    report_mismatch($sformatf("out_flit[%0d]", o), held_flit[o], out_flit[o]);
                was_stalled[o] = out_valid[o] && !out_ready[o];
                held_flit[o] = out_flit[o];
                if (out_valid[o] && out_ready[o]) begin
                    src = int'(out_flit[o][26:25]);
                    vc = int'(out_flit[o][FLIT_VC_BIT]);
                    qi = q_index(o, src, vc);
                    if (hot_mode)
                        for (int i = 0; i < NUM_PORTS; i++) begin
                            backlog = exp_q[q_index(o, i, 0)].size() +
                                      exp_q[q_index(o, i, 1)].size();
                            if (i == src || backlog == 0) begin
                                wait_cnt[i] = 0;
                            end else begin
                                wait_cnt[i]++;
                                if (wait_cnt[i] > NUM_PORTS)
                                    report_problem($sformatf("input %0d starved at output %0d",
                                                             i, o));
                            end
                        end
                    if (src >= NUM_PORTS || exp_q[qi].size() == 0) begin
                        report_problem($sformatf("unexpected flit %h at output %0d",
                                                 out_flit[o], o));
                    end else begin
                        exp = exp_q[qi].pop_front();
                        pending--;
                        if (out_flit[o] !== exp)
                            report_mismatch($sformatf("out_flit[%0d]", o), exp, out_flit[o]);
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] rdata;
        logic err;
        int start;
        clk = 1'b0;
        n_rst = 1'b0;
        in_valid = '0;
        out_ready = '1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsr = 32'ha41c;
        {pending, errors, tests_run, tests_failed, cycles} = '0;
        {hot_mode, saw_full, was_stalled} = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_flit[p] = '0;
            wait_cnt[p] = 0;
            seq_cnt[p][0] = '0;
            seq_cnt[p][1] = '0;
        end
        for (int n = 0; n < TABLE_SIZE; n++)
            shadow[n] = port_sel_t'(n % NUM_PORTS);
        repeat (4) @(posedge clk);
        n_rst <= 1'b1;

        start = errors;
        check_table();
        @(negedge clk);
        if (out_valid !== '0)
            report_mismatch("out_valid", '0, 32'(out_valid));
        if (in_ready_vc0 !== '1 || in_ready_vc1 !== '1)
            report_problem("in_ready low after reset");
        finish_test("reset_defaults", start);

        start = errors;
        for (int p = 0; p < NUM_PORTS; p++)
            for (int d = 0; d < TABLE_SIZE; d++)
                run_traffic(1, 1'b0, d, p);
        finish_test("single_default", start);

        start = errors;
        for (int n = 0; n < TABLE_SIZE; n++) begin
            shadow[n] = port_sel_t'(rand_bits(2) % 3);
            apb_access(1'b1, 8'(4 * n), 32'(shadow[n]), rdata, err);
            if (err)
                report_problem($sformatf("pslverr on valid write of entry %0d", n));
        end
        check_table();
        // Address 64 aliases entry 0 in the low index bits
        apb_access(1'b1, 8'd64, 32'((int'(shadow[0]) + 1) % 3), rdata, err);
        if (!err)
            report_problem("no pslverr on write above the table");
        apb_access(1'b0, 8'd64, '0, rdata, err);
        if (!err)
            report_problem("no pslverr on read above the table");
        apb_access(1'b1, 8'd20, 32'd3, rdata, err);
        if (!err)
            report_problem("no pslverr on write of port 3");
        check_table();
        finish_test("program_map", start);

        start = errors;
        for (int p = 0; p < NUM_PORTS; p++)
            for (int d = 0; d < TABLE_SIZE; d++)
                run_traffic(1, 1'b0, d, p);
        finish_test("single_programmed", start);

        start = errors;
        run_traffic(40, 1'b0, -1, -1);
        finish_test("random_traffic", start);

        start = errors;
        saw_full = 1'b0;
        run_traffic(40, 1'b1, -1, -1);
        if (!saw_full)
            report_problem("in_ready never fell during output stalls");
        finish_test("random_stall", start);

        start = errors;
        hot_mode = 1'b1;
        run_traffic(30, 1'b0, 0, -1);  // Every flit to node 0
        hot_mode = 1'b0;
        finish_test("hotspot", start);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: noc_switch.f
verilog/noc_pkg.sv
verilog/flit_fifo.sv
verilog/route_table.sv
verilog/switch_allocator.sv
verilog/crossbar.sv
verilog/noc_switch.sv
tb/noc_switch_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= noc_switch_tb
FILELIST  ?= noc_switch.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
